/* rtl/icache_pkg.sv */
// shared geometry, address fields and array entry types of the instruction cache, used by scoped names
`default_nettype none

package icache_pkg;

  // physical address and fetch width
  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned FETCH_W  = 32;

  // one line holds four fetch words
  localparam int unsigned LINE_W   = 128;

  // 4 ways x 64 sets x 16 bytes = 4 KiB
  localparam int unsigned NUM_WAYS = 4;
  localparam int unsigned NUM_SETS = 64;

  // address split: tag | index | offset
  localparam int unsigned OFFSET_W = 4;
  localparam int unsigned INDEX_W  = 6;
  // top tag bit doubles as the non-cacheable marker
  localparam int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int unsigned WAY_W    = 2;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [FETCH_W-1:0]  word_t;

  // one bit per way, used both one-hot and as a request mask
  typedef logic [NUM_WAYS-1:0] way_oh_t;
  typedef logic [WAY_W-1:0]    way_idx_t;

  // tag ram word, valid bit on top
  typedef struct packed {
    logic valid;
    tag_t tag;
  } tag_entry_t;

endpackage

`default_nettype wire

/* rtl/icache_array_if.sv */
// bundle between the cache controller and the tag and data storage, ctrl side writes, store side reads back
`timescale 1ns/1ps
`default_nettype none

interface icache_array_if;

  // per-way request enables
  icache_pkg::way_oh_t req_mask;
  // write when high, lookup read when low
  logic                we;
  icache_pkg::index_t  index;
  // tag entry for fills and clears, a clear has valid low
  icache_pkg::tag_entry_t wtag;
  // line for fills only
  icache_pkg::line_t      wline;

  // read data, one cycle after a read request
  icache_pkg::tag_entry_t [icache_pkg::NUM_WAYS-1:0] rtag;
  icache_pkg::line_t      [icache_pkg::NUM_WAYS-1:0] rline;

  modport ctrl (
    output req_mask, we, index, wtag, wline,
    input  rtag, rline
  );

  modport store (
    input  req_mask, we, index, wtag, wline,
    output rtag, rline
  );

endinterface

`default_nettype wire

/* rtl/icache_sram.sv */
// single-port synchronous ram with registered read, payload given by a type parameter
`timescale 1ns/1ps
`default_nettype none

module icache_sram #(
  parameter type         word_type = logic [31:0],
  parameter int unsigned depth     = icache_pkg::NUM_SETS
) (
  input  wire logic               clk_i,
  input  wire logic               req_i,
  input  wire logic               we_i,
  input  wire icache_pkg::index_t addr_i,
  input  wire word_type           wdata_i,
  output      word_type           rdata_o
);

  // storage, contents undefined until written
  word_type mem_q [depth];

  // write or read, never both
  // read data holds while the ram is idle or writing
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/icache_store.sv */
// tag and data rams of all ways, driven by the controller through the array interface
`timescale 1ns/1ps
`default_nettype none

module icache_store (
  input wire logic  clk_i,
  icache_array_if.store arr
);

  // data rams only see lookups and fills
  // a clear is a tag write with the valid bit low
  icache_pkg::way_oh_t data_req;

  for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : gen_way

    assign data_req[w] = arr.req_mask[w] & (~arr.we | arr.wtag.valid);

    // valid bit plus tag
    icache_sram #(
      .word_type (icache_pkg::tag_entry_t),
      .depth     (icache_pkg::NUM_SETS)
    ) tag_sram_inst (
      .clk_i   (clk_i),
      .req_i   (arr.req_mask[w]),
      .we_i    (arr.we),
      .addr_i  (arr.index),
      .wdata_i (arr.wtag),
      .rdata_o (arr.rtag[w])
    );

    // full line from the refill port
    icache_sram #(
      .word_type (icache_pkg::line_t),
      .depth     (icache_pkg::NUM_SETS)
    ) data_sram_inst (
      .clk_i   (clk_i),
      .req_i   (data_req[w]),
      .we_i    (arr.we),
      .addr_i  (arr.index),
      .wdata_i (arr.wline),
      .rdata_o (arr.rline[w])
    );

  end

endmodule

`default_nettype wire

/* rtl/icache_lookup.sv */
// tag compare over all ways and selection of the fetch word from the hitting line
`timescale 1ns/1ps
`default_nettype none

module icache_lookup (
  input  wire icache_pkg::tag_entry_t [icache_pkg::NUM_WAYS-1:0] rtag_i,
  input  wire icache_pkg::line_t      [icache_pkg::NUM_WAYS-1:0] rline_i,
  input  wire icache_pkg::tag_t                                  tag_i,
  input  wire icache_pkg::offset_t                               offset_i,
  output      logic                                              hit_o,
  output      icache_pkg::word_t                                 word_o
);

  icache_pkg::way_oh_t  hit_vec;
  icache_pkg::way_idx_t hit_way;
  // word number inside the line
  logic [icache_pkg::OFFSET_W-3:0] word_sel;

  // per-way compare, only valid entries count
  always_comb begin
    hit_vec = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      hit_vec[w] = rtag_i[w].valid && (rtag_i[w].tag == tag_i);
    end
  end

  // lowest hitting way wins
  // more than one hit would be a tag duplicate
  always_comb begin
    hit_way = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way = icache_pkg::way_idx_t'(w);
      end
    end
  end

  assign hit_o = |hit_vec;

  // byte offset down to word lanes, low two bits ignored
  assign word_sel = offset_i[icache_pkg::OFFSET_W-1:2];
  assign word_o   = rline_i[hit_way][word_sel*icache_pkg::FETCH_W +: icache_pkg::FETCH_W];

endmodule

`default_nettype wire

/* rtl/icache_replace.sv */
// victim way choice for refills, first invalid way or a pseudo-random one when the set is full
`timescale 1ns/1ps
`default_nettype none

module icache_replace (
  input  wire logic                                              clk_i,
  input  wire logic                                              rst_ni,
  input  wire icache_pkg::tag_entry_t [icache_pkg::NUM_WAYS-1:0] rtag_i,
  input  wire logic                                              advance_i,
  output      icache_pkg::way_oh_t                               victim_o
);

  icache_pkg::way_idx_t inv_way;
  icache_pkg::way_idx_t victim_idx;
  logic                 all_valid;
  // 8 bit galois-free fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
  logic [7:0]           lfsr_q;
  logic                 lfsr_fb;

  // scan from the top so the lowest invalid way is left standing
  always_comb begin
    inv_way   = '0;
    all_valid = 1'b1;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!rtag_i[w].valid) begin
        inv_way   = icache_pkg::way_idx_t'(w);
        all_valid = 1'b0;
      end
    end
  end

  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // read data still shows the looked-up set during the fill,
  // so only fills into a full set step the sequence
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'h01;
    end else if (advance_i && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

  assign victim_idx = all_valid ? lfsr_q[icache_pkg::WAY_W-1:0] : inv_way;
  assign victim_o   = icache_pkg::way_oh_t'(1) << victim_idx;

endmodule

`default_nettype wire

/* rtl/icache_ctrl.sv */
// cache controller, runs clears, lookups and refills and drives the fetch and refill ports
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                en_i,
  input  wire logic                flush_i,
  // fetch port
  input  wire logic                fetch_req_i,
  input  wire icache_pkg::addr_t   fetch_addr_i,
  output      logic                fetch_ready_o,
  output      logic                fetch_valid_o,
  output      icache_pkg::word_t   fetch_data_o,
  // refill port
  output      logic                mem_req_o,
  input  wire logic                mem_ack_i,
  output      icache_pkg::addr_t   mem_addr_o,
  output      logic                mem_nc_o,
  input  wire logic                mem_rtrn_vld_i,
  input  wire icache_pkg::line_t   mem_rtrn_data_i,
  output      logic                miss_o,
  output      logic                busy_o,
  // lookup and replacement
  input  wire logic                hit_i,
  input  wire icache_pkg::word_t   word_i,
  output      icache_pkg::tag_t    tag_o,
  output      icache_pkg::offset_t offset_o,
  input  wire icache_pkg::way_oh_t victim_i,
  output      logic                advance_o,
  icache_array_if.ctrl             arr
);

  typedef enum logic [1:0] {FLUSH, IDLE, READ, MISS} state_e;

  state_e              state_d, state_q;
  logic                cache_en_d, cache_en_q;
  // pending flush request
  logic                flush_d, flush_q;
  icache_pkg::index_t  flush_cnt_d, flush_cnt_q;
  logic                flush_done;
  // registered hit pulse
  logic                valid_d, valid_q;
  logic                accept;
  logic                cacheable;
  icache_pkg::tag_t    tag_q;
  icache_pkg::index_t  index_q;
  icache_pkg::offset_t offset_q;
  icache_pkg::way_oh_t victim_q;
  icache_pkg::word_t   rtrn_word;

  //////////////////////////////////////////////////////////////////////
  // request fields and refill address
  //////////////////////////////////////////////////////////////////////

  // upper half of the address space bypasses the arrays
  assign cacheable  = cache_en_q & ~tag_q[icache_pkg::TAG_W-1];
  assign mem_nc_o   = ~cacheable;
  // line address for fills, word address for uncached reads
  assign mem_addr_o = cacheable ? {tag_q, index_q, {icache_pkg::OFFSET_W{1'b0}}} :
                                  {tag_q, index_q, offset_q[icache_pkg::OFFSET_W-1:2], 2'b00};

  assign tag_o    = tag_q;
  assign offset_o = offset_q;

  // the returned line carries the word in its natural lane
  assign rtrn_word = mem_rtrn_data_i[offset_q[icache_pkg::OFFSET_W-1:2]*icache_pkg::FETCH_W +:
                                     icache_pkg::FETCH_W];

  assign flush_done = (flush_cnt_q == icache_pkg::index_t'(icache_pkg::NUM_SETS - 1));

  assign busy_o        = (state_q != IDLE);
  // hits come from the register, fills straight from the return port
  assign fetch_valid_o = valid_q | ((state_q == MISS) & mem_rtrn_vld_i);
  assign fetch_data_o  = (state_q == MISS) ? rtrn_word : word_i;

  //////////////////////////////////////////////////////////////////////
  // main fsm
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    cache_en_d    = cache_en_q;
    flush_d       = flush_q | flush_i;
    flush_cnt_d   = flush_cnt_q;
    valid_d       = 1'b0;
    accept        = 1'b0;
    fetch_ready_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    advance_o     = 1'b0;
    // array defaults match a fill of the current request
    arr.req_mask  = '0;
    arr.we        = 1'b0;
    arr.index     = index_q;
    arr.wtag      = '{valid: 1'b1, tag: tag_q};
    arr.wline     = mem_rtrn_data_i;

    unique case (state_q)
      // clear one set per cycle in all ways
      FLUSH: begin
        arr.req_mask = '1;
        arr.we       = 1'b1;
        arr.index    = flush_cnt_q;
        arr.wtag     = '0;
        flush_cnt_d  = flush_cnt_q + 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          // enable takes effect only from a clean array
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        // disabling needs no clear
        cache_en_d = cache_en_q & en_i;
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            // read the whole set, result in READ
            accept       = 1'b1;
            arr.req_mask = '1;
            arr.index    = fetch_addr_i[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
            state_d      = READ;
          end
        end
      end
      // hit check, or hold the refill request until acknowledged
      READ: begin
        if (cacheable && hit_i) begin
          valid_d = 1'b1;
          state_d = IDLE;
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            // only real misses count
            miss_o  = cacheable;
            state_d = MISS;
          end
        end
      end
      // return is taken unconditionally
      MISS: begin
        if (mem_rtrn_vld_i) begin
          state_d = IDLE;
          if (cacheable) begin
            arr.req_mask = victim_q;
            arr.we       = 1'b1;
            advance_o    = 1'b1;
          end
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////////////////////////

  // reset starts with a full clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
      valid_q     <= 1'b0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
      valid_q     <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tag_q    <= fetch_addr_i[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
      index_q  <= fetch_addr_i[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
      offset_q <= fetch_addr_i[icache_pkg::OFFSET_W-1:0];
    end
    // victim is taken from the looked-up set
    if ((state_q == READ) && (state_d == MISS)) begin
      victim_q <= victim_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
// instruction cache top level with plain fetch and refill ports
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire logic              clk_i,
  input  wire logic              rst_ni,
  input  wire logic              en_i,
  input  wire logic              flush_i,
  input  wire logic              fetch_req_i,
  input  wire icache_pkg::addr_t fetch_addr_i,
  output      logic              fetch_ready_o,
  output      logic              fetch_valid_o,
  output      icache_pkg::word_t fetch_data_o,
  output      logic              mem_req_o,
  input  wire logic              mem_ack_i,
  output      icache_pkg::addr_t mem_addr_o,
  output      logic              mem_nc_o,
  input  wire logic              mem_rtrn_vld_i,
  input  wire icache_pkg::line_t mem_rtrn_data_i,
  output      logic              miss_o,
  output      logic              busy_o
);

  logic                hit;
  icache_pkg::word_t   word;
  icache_pkg::tag_t    req_tag;
  icache_pkg::offset_t req_offset;
  icache_pkg::way_oh_t victim;
  logic                advance;

  icache_array_if arr_if ();

  icache_ctrl icache_ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .mem_req_o       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .miss_o          (miss_o),
    .busy_o          (busy_o),
    .hit_i           (hit),
    .word_i          (word),
    .tag_o           (req_tag),
    .offset_o        (req_offset),
    .victim_i        (victim),
    .advance_o       (advance),
    .arr             (arr_if.ctrl)
  );

  icache_store icache_store_inst (
    .clk_i (clk_i),
    .arr   (arr_if.store)
  );

  // both work on the registered read data
  icache_lookup icache_lookup_inst (
    .rtag_i   (arr_if.rtag),
    .rline_i  (arr_if.rline),
    .tag_i    (req_tag),
    .offset_i (req_offset),
    .hit_o    (hit),
    .word_o   (word)
  );

  icache_replace icache_replace_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rtag_i    (arr_if.rtag),
    .advance_i (advance),
    .victim_o  (victim)
  );

endmodule

`default_nettype wire

/* bench/icache_assertions.sv */
// concurrent checks on the cache controller, bound into every icache_ctrl instance
`timescale 1ns/1ps
`default_nettype none

module icache_assertions (
  input wire logic                                              clk_i,
  input wire logic                                              rst_ni,
  input wire logic [1:0]                                        state_i,
  input wire icache_pkg::tag_t                                  tag_i,
  input wire icache_pkg::tag_entry_t [icache_pkg::NUM_WAYS-1:0] rtag_i,
  input wire logic                                              we_i,
  input wire logic                                              wtag_valid_i,
  input wire logic                                              mem_req_i,
  input wire logic                                              mem_ack_i,
  input wire icache_pkg::addr_t                                 mem_addr_i,
  input wire logic                                              mem_nc_i
);

  // controller encoding: FLUSH 0, IDLE 1, READ 2, MISS 3
  logic                in_flush;
  logic                in_read;
  icache_pkg::way_oh_t hit_vec;
  icache_pkg::way_oh_t valid_vec;
  // high from a clear until the next fill
  logic                clean_q;

  assign in_flush = (state_i == 2'd0);
  assign in_read  = (state_i == 2'd2);

  // same compare as the lookup, on the registered read data, plus the valid bits
  always_comb begin
    hit_vec   = '0;
    valid_vec = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
      hit_vec[w]   = rtag_i[w].valid && (rtag_i[w].tag == tag_i);
      valid_vec[w] = rtag_i[w].valid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clean_q <= 1'b0;
    end else if (in_flush) begin
      clean_q <= 1'b1;
    end else if (we_i && wtag_valid_i) begin
      clean_q <= 1'b0;
    end
  end

  state_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(state_i))
    else $error("controller state is unknown");

  // a duplicate tag in one set would show as two hits
  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_read |-> $onehot0(hit_vec))
    else $error("more than one way hits");

  // nothing valid comes out of a clear, so lookups before the next fill see an empty set
  no_fill_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_read && clean_q) |-> (valid_vec == '0))
    else $error("valid entry read back after a clear");

  mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i && !mem_ack_i) |=> (mem_req_i && $stable(mem_addr_i) && $stable(mem_nc_i)))
    else $error("refill request dropped or changed before the acknowledge");

endmodule

bind icache_ctrl icache_assertions icache_assertions_inst (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .state_i      (state_q),
  .tag_i        (tag_q),
  .rtag_i       (arr.rtag),
  .we_i         (arr.we),
  .wtag_valid_i (arr.wtag.valid),
  .mem_req_i    (mem_req_o),
  .mem_ack_i    (mem_ack_i),
  .mem_addr_i   (mem_addr_o),
  .mem_nc_i     (mem_nc_o)
);

`default_nettype wire

/* bench/tb_icache.sv */
// testbench for the instruction cache, runs a fetch table through the top level against a memory model
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  // memory word at word address A reads A xor this pattern
  localparam logic [31:0] MEM_XOR = 32'h5a5a_0000;
  // longest any single wait may take, in cycles
  localparam int          TIMEOUT = 200;

  typedef struct packed {
    logic              en;
    logic              flush;
    icache_pkg::addr_t addr;
    logic              exp_mem;
    logic              exp_miss;
    icache_pkg::word_t exp_word;
  } row_t;

  logic              clk_i;
  logic              rst_ni;
  logic              en_i;
  logic              flush_i;
  logic              fetch_req_i;
  icache_pkg::addr_t fetch_addr_i;
  logic              fetch_ready_o;
  logic              fetch_valid_o;
  icache_pkg::word_t fetch_data_o;
  logic              mem_req_o;
  logic              mem_ack_i;
  icache_pkg::addr_t mem_addr_o;
  logic              mem_nc_o;
  logic              mem_rtrn_vld_i;
  icache_pkg::line_t mem_rtrn_data_i;
  logic              miss_o;
  logic              busy_o;

  // stimulus table, names kept alongside
  row_t        rows[$];
  string       names[$];

  // refill port values the current row should produce
  string             cur_name;
  icache_pkg::addr_t exp_addr;
  logic              exp_nc;

  // free running event counters, differenced per row
  int unsigned mem_req_cnt = 0;
  int unsigned miss_cnt    = 0;
  int          checks      = 0;
  int          errors      = 0;
  int          timeouts    = 0;

  icache_top icache_top_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .mem_req_o       (mem_req_o),
    .mem_ack_i       (mem_ack_i),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .miss_o          (miss_o),
    .busy_o          (busy_o)
  );

  // 20 ns period
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  // whole line around addr, each word follows the memory rule
  function automatic icache_pkg::line_t line_for(input icache_pkg::addr_t addr);
    icache_pkg::line_t line;
    for (int i = 0; i < 4; i++) begin
      line[i*32 +: 32] = {addr[31:4], 2'(i), 2'b00} ^ MEM_XOR;
    end
    return line;
  endfunction

  initial begin : memory_model
    int unsigned       delay;
    icache_pkg::line_t line;
    void'($urandom(32'hb841));
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    forever begin
      @(posedge clk_i);
      if (mem_req_o) begin
        // fills ask for the line, uncached reads for the word
        check_value({cur_name, " mem address"}, exp_addr, mem_addr_o);
        check_value({cur_name, " mem nc"}, 32'(exp_nc), 32'(mem_nc_o));
        // acknowledge after 0 to 3 more cycles
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk_i);
        line = line_for(mem_addr_o);
        mem_ack_i <= 1'b1;
        @(posedge clk_i);
        mem_ack_i <= 1'b0;
        // return 1 to 4 cycles after the acknowledge
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge clk_i);
        mem_rtrn_data_i <= line;
        mem_rtrn_vld_i  <= 1'b1;
        @(posedge clk_i);
        mem_rtrn_vld_i  <= 1'b0;
      end
    end
  end

  // one count per acknowledged request and per miss pulse
  always @(posedge clk_i) begin
    if (mem_req_o && mem_ack_i) begin
      mem_req_cnt <= mem_req_cnt + 1;
    end
    if (miss_o) begin
      miss_cnt <= miss_cnt + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input string name, input logic en, input logic flush,
                         input icache_pkg::addr_t addr, input logic exp_mem,
                         input logic exp_miss, input icache_pkg::word_t exp_word);
    rows.push_back('{en, flush, addr, exp_mem, exp_miss, exp_word});
    names.push_back(name);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", what, expected, actual);
    end
  endtask

  // a clear keeps busy_o high for one cycle per set
  task automatic measure_clear(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (busy_o && cycles < TIMEOUT) begin
      cycles++;
      @(negedge clk_i);
    end
    if (busy_o) begin
      timeouts++;
      $display("timeout in %s: busy_o stayed high for %0d cycles", what, TIMEOUT);
    end else begin
      check_value({what, " clear cycles"}, icache_pkg::NUM_SETS, cycles);
    end
  endtask

  // one fetch through the ready and valid handshake
  task automatic run_fetch(input string what, input icache_pkg::addr_t addr,
                           output icache_pkg::word_t data, output bit ok);
    int cycles;
    ok   = 1'b0;
    data = '0;
    @(posedge clk_i);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= addr;
    // ready stays low through a whole clear
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!fetch_ready_o && cycles < TIMEOUT);
    if (!fetch_ready_o) begin
      timeouts++;
      $display("timeout in %s: fetch_ready_o stayed low for %0d cycles", what, TIMEOUT);
    end else begin
      // accepting edge
      @(posedge clk_i);
      fetch_req_i <= 1'b0;
      cycles = 0;
      do begin
        @(negedge clk_i);
        cycles++;
      end while (!fetch_valid_o && cycles < TIMEOUT);
      if (!fetch_valid_o) begin
        timeouts++;
        $display("timeout in %s: no fetch_valid_o within %0d cycles", what, TIMEOUT);
      end else begin
        data = fetch_data_o;
        ok   = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // cache still off after reset, every fetch goes out
    add_row("off_first",     1'b0, 1'b0, 32'h0000_0100, 1'b1, 1'b0, 32'h5a5a_0100);
    add_row("off_again",     1'b0, 1'b0, 32'h0000_0100, 1'b1, 1'b0, 32'h5a5a_0100);
    // turning on clears, then miss and hits in one line
    add_row("on_miss",       1'b1, 1'b0, 32'h0000_1234, 1'b1, 1'b1, 32'h5a5a_1234);
    add_row("on_hit_word",   1'b1, 1'b0, 32'h0000_1234, 1'b0, 1'b0, 32'h5a5a_1234);
    add_row("on_hit_lane0",  1'b1, 1'b0, 32'h0000_1230, 1'b0, 1'b0, 32'h5a5a_1230);
    add_row("on_hit_lane2",  1'b1, 1'b0, 32'h0000_1238, 1'b0, 1'b0, 32'h5a5a_1238);
    add_row("on_hit_byte",   1'b1, 1'b0, 32'h0000_123e, 1'b0, 1'b0, 32'h5a5a_123c);
    // upper half is never cached
    add_row("nc_first",      1'b1, 1'b0, 32'h8000_0040, 1'b1, 1'b0, 32'hda5a_0040);
    add_row("nc_again",      1'b1, 1'b0, 32'h8000_0040, 1'b1, 1'b0, 32'hda5a_0040);
    add_row("nc_same_line",  1'b1, 1'b0, 32'h8000_0048, 1'b1, 1'b0, 32'hda5a_0048);
    // flush drops the cached line
    add_row("flush_miss",    1'b1, 1'b1, 32'h0000_1234, 1'b1, 1'b1, 32'h5a5a_1234);
    add_row("flush_refill",  1'b1, 1'b0, 32'h0000_1234, 1'b0, 1'b0, 32'h5a5a_1234);
    // four tags into set 5, one per way
    add_row("set_fill_0",    1'b1, 1'b0, 32'h0000_2050, 1'b1, 1'b1, 32'h5a5a_2050);
    add_row("set_fill_1",    1'b1, 1'b0, 32'h0000_2454, 1'b1, 1'b1, 32'h5a5a_2454);
    add_row("set_fill_2",    1'b1, 1'b0, 32'h0000_2858, 1'b1, 1'b1, 32'h5a5a_2858);
    add_row("set_fill_3",    1'b1, 1'b0, 32'h0000_2c5c, 1'b1, 1'b1, 32'h5a5a_2c5c);
    add_row("set_hit_0",     1'b1, 1'b0, 32'h0000_205c, 1'b0, 1'b0, 32'h5a5a_205c);
    add_row("set_hit_1",     1'b1, 1'b0, 32'h0000_2450, 1'b0, 1'b0, 32'h5a5a_2450);
    add_row("set_hit_2",     1'b1, 1'b0, 32'h0000_2854, 1'b0, 1'b0, 32'h5a5a_2854);
    add_row("set_hit_3",     1'b1, 1'b0, 32'h0000_2c58, 1'b0, 1'b0, 32'h5a5a_2c58);
    // fifth tag evicts a random way
    add_row("set_fifth",     1'b1, 1'b0, 32'h0000_3050, 1'b1, 1'b1, 32'h5a5a_3050);
    add_row("set_fifth_hit", 1'b1, 1'b0, 32'h0000_3054, 1'b0, 1'b0, 32'h5a5a_3054);
    // off again, then back on through a clear
    add_row("off_later",     1'b0, 1'b0, 32'h0000_1234, 1'b1, 1'b0, 32'h5a5a_1234);
    add_row("off_later_rep", 1'b0, 1'b0, 32'h0000_1234, 1'b1, 1'b0, 32'h5a5a_1234);
    add_row("on_again_miss", 1'b1, 1'b0, 32'h0000_1234, 1'b1, 1'b1, 32'h5a5a_1234);
    add_row("on_again_hit",  1'b1, 1'b0, 32'h0000_1234, 1'b0, 1'b0, 32'h5a5a_1234);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    row_t              row;
    string             name;
    int unsigned       req_start;
    int unsigned       miss_start;
    icache_pkg::word_t data;
    bit                ok;
    logic              prev_en;
    rst_ni       = 1'b0;
    en_i         = 1'b0;
    flush_i      = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    cur_name     = "reset";
    exp_addr     = '0;
    exp_nc       = 1'b1;
    prev_en      = 1'b0;
    build_table();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    measure_clear("reset");
    for (int i = 0; i < rows.size(); i++) begin
      row  = rows[i];
      name = names[i];
      // enable level and a one-cycle flush pulse
      @(posedge clk_i);
      en_i    <= row.en;
      flush_i <= row.flush;
      @(posedge clk_i);
      flush_i <= 1'b0;
      // a flush or a rising enable runs one full clear first
      if (row.flush || (row.en && !prev_en)) begin
        measure_clear(name);
      end
      prev_en = row.en;
      // uncached reads ask for the word, fills for the whole line
      exp_nc     = !row.en || row.addr[31];
      exp_addr   = exp_nc ? {row.addr[31:2], 2'b00} : {row.addr[31:4], 4'h0};
      cur_name   = name;
      req_start  = mem_req_cnt;
      miss_start = miss_cnt;
      run_fetch(name, row.addr, data, ok);
      if (!ok) begin
        break;
      end
      check_value({name, " data"}, row.exp_word, data);
      check_value({name, " mem requests"}, 32'(row.exp_mem), mem_req_cnt - req_start);
      check_value({name, " miss pulses"}, 32'(row.exp_miss), miss_cnt - miss_start);
    end
    $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/icache_pkg.sv
rtl/icache_array_if.sv
rtl/icache_sram.sv
rtl/icache_store.sv
rtl/icache_lookup.sv
rtl/icache_replace.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
bench/icache_assertions.sv
bench/tb_icache.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it, and looks for the pass line in sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_icache -f verilog.f -o tb_icache \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_icache > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
